/* source/rdma_pkg.sv */
/*
 * Opcodes, field widths, command structs and the 64-bit network
 * header word shared by the RDMA reliable-connection engine
 */
package rdma_pkg;

  // Field widths
  localparam int OP_BITS    = 4;
  localparam int QPN_BITS   = 4;
  localparam int PSN_BITS   = 24;
  localparam int PID_BITS   = 4;
  localparam int VADDR_BITS = 16;
  localparam int LEN_BITS   = 12;

  // Padding that fills the ACK view up to 64 bits
  localparam int ACK_RSVD_BITS = 64 - OP_BITS - QPN_BITS - PSN_BITS - PID_BITS - 1;

  // Opcodes
  localparam logic [OP_BITS-1:0] OP_WRITE = 4'd1;
  localparam logic [OP_BITS-1:0] OP_ACK   = 4'd2;

  // User command on the send queue
  typedef struct packed {
    logic [OP_BITS-1:0]    opcode;
    logic [QPN_BITS-1:0]   qpn;
    logic [PID_BITS-1:0]   pid;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
  } rdma_sq_t;

  // Memory read or write request
  typedef struct packed {
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
    logic [PID_BITS-1:0]   pid;
  } mem_cmd_t;

  // Completion handed back to the user
  typedef struct packed {
    logic [QPN_BITS-1:0] qpn;
    logic [PID_BITS-1:0] pid;
    logic                is_nak;
  } rdma_ack_t;

  // ACK or NAK to be sent, from the receive side to the transmit side
  typedef struct packed {
    logic [QPN_BITS-1:0] qpn;
    logic [PSN_BITS-1:0] psn;
    logic [PID_BITS-1:0] pid;
    logic                is_nak;
  } ack_req_t;

  // Request header view
  typedef struct packed {
    logic [OP_BITS-1:0]    opcode;
    logic [QPN_BITS-1:0]   qpn;
    logic [PSN_BITS-1:0]   psn;
    logic [PID_BITS-1:0]   pid;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
  } net_req_t;

  // ACK header view, reserved bits sent as zero
  typedef struct packed {
    logic [OP_BITS-1:0]       opcode;
    logic [QPN_BITS-1:0]      qpn;
    logic [PSN_BITS-1:0]      psn;
    logic [PID_BITS-1:0]      pid;
    logic                     is_nak;
    logic [ACK_RSVD_BITS-1:0] rsvd;
  } net_ack_t;

  // One network word, decoded by its leading opcode
  typedef union packed {
    net_req_t req;
    net_ack_t ack;
  } net_word_u;

endpackage

/* source/sq_flow_ctrl.sv */
/*
 * Send queue flow control, counts commands in flight
 * and holds off the user at the outstanding limit
 */
`timescale 1ns/1ps

module sq_flow_ctrl #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic nclk,
  input  logic nresetn,
  input  logic sq_valid,
  input  logic tx_sq_ready,
  input  logic ack_valid,
  output logic sq_ready,
  output logic sq_accept
);

  localparam int CNT_BITS = $clog2(MAX_OUTSTANDING + 1);

  // Commands sent but not yet acknowledged
  logic [CNT_BITS-1:0] cnt_outst;

  assign sq_ready  = (cnt_outst < CNT_BITS'(MAX_OUTSTANDING)) && tx_sq_ready;
  assign sq_accept = sq_valid && sq_ready;

  // Accept and ack in the same cycle cancel out
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      cnt_outst <= '0;
    end else if (sq_accept && !ack_valid) begin
      cnt_outst <= cnt_outst + 1'b1;
    end else if (ack_valid && !sq_accept && (cnt_outst != '0)) begin
      cnt_outst <= cnt_outst - 1'b1;
    end
  end

  cnt_limit_a: assert property (
    @(posedge nclk) disable iff (!nresetn)
    cnt_outst <= CNT_BITS'(MAX_OUTSTANDING)
  ) else $error("outstanding count above MAX_OUTSTANDING");

  // Remote side must only ack what was sent
  ack_no_cmd_a: assert property (
    @(posedge nclk) disable iff (!nresetn)
    ack_valid |-> (cnt_outst != '0)
  ) else $error("ack received with no command outstanding");

endmodule

/* source/tx_engine.sv */
/*
 * Transmit engine, builds request and ACK header words,
 * keeps the per-QP send PSN and issues memory read requests
 */
`timescale 1ns/1ps

module tx_engine
  import rdma_pkg::*;
#(
  parameter int N_QP = 4
) (
  input  logic      nclk,
  input  logic      nresetn,
  input  logic      sq_accept,
  input  rdma_sq_t  sq_data,
  input  logic      ack_req_valid,
  input  ack_req_t  ack_req,
  output logic      tx_sq_ready,
  output logic      tx_valid,
  output net_word_u tx_data,
  output logic      rd_req_valid,
  output mem_cmd_t  rd_req_data
);

  localparam int QP_IDX_BITS = (N_QP > 1) ? $clog2(N_QP) : 1;

  logic [PSN_BITS-1:0]    send_psn [N_QP];
  logic [QP_IDX_BITS-1:0] sq_qp;
  logic                   sq_take;
  net_word_u              tx_word;

  assign sq_qp   = sq_data.qpn[QP_IDX_BITS-1:0];
  assign sq_take = sq_accept && !ack_req_valid;

  // ACK requests win the tx slot
  assign tx_sq_ready = !ack_req_valid;

  always_comb begin
    tx_word = '0;
    if (ack_req_valid) begin
      tx_word.ack.opcode = OP_ACK;
      tx_word.ack.qpn    = ack_req.qpn;
      tx_word.ack.psn    = ack_req.psn;
      tx_word.ack.pid    = ack_req.pid;
      tx_word.ack.is_nak = ack_req.is_nak;
    end else begin
      tx_word.req.opcode = sq_data.opcode;
      tx_word.req.qpn    = sq_data.qpn;
      tx_word.req.psn    = send_psn[sq_qp];
      tx_word.req.pid    = sq_data.pid;
      tx_word.req.vaddr  = sq_data.vaddr;
      tx_word.req.len    = sq_data.len;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      tx_valid     <= 1'b0;
      rd_req_valid <= 1'b0;
      for (int i = 0; i < N_QP; i++) begin
        send_psn[i] <= '0;
      end
    end else begin
      tx_valid     <= ack_req_valid || sq_accept;
      rd_req_valid <= sq_take;
      if (sq_take) begin
        send_psn[sq_qp] <= send_psn[sq_qp] + 1'b1;
      end
    end
  end

  // Header and read request payload
  always_ff @(posedge nclk) begin
    tx_data           <= tx_word;
    rd_req_data.vaddr <= sq_data.vaddr;
    rd_req_data.len   <= sq_data.len;
    rd_req_data.pid   <= sq_data.pid;
  end

  // Flow control must hold the send queue while an ACK is pending
  accept_vs_ack_a: assert property (
    @(posedge nclk) disable iff (!nresetn)
    sq_accept |-> !ack_req_valid
  ) else $error("send command accepted in an ACK cycle");

endmodule

/* source/rx_engine.sv */
/*
 * Receive engine, decodes network words, checks the PSN per QP,
 * issues memory writes, ACK/NAK requests and user completions
 */
`timescale 1ns/1ps

module rx_engine
  import rdma_pkg::*;
#(
  parameter int N_QP = 4
) (
  input  logic      nclk,
  input  logic      nresetn,
  input  logic      rx_valid,
  input  net_word_u rx_data,
  output logic      wr_req_valid,
  output mem_cmd_t  wr_req_data,
  output logic      ack_req_valid,
  output ack_req_t  ack_req,
  output logic      ack_valid,
  output rdma_ack_t ack_data,
  output logic      psn_drop
);

  localparam int QP_IDX_BITS = (N_QP > 1) ? $clog2(N_QP) : 1;

  logic [PSN_BITS-1:0]    exp_psn [N_QP];
  logic [QP_IDX_BITS-1:0] rx_qp;
  logic                   is_write;
  logic                   is_ack;
  logic                   in_order;

  assign rx_qp = rx_data.req.qpn[QP_IDX_BITS-1:0];

  // Opcode sits in the same bits in both views
  assign is_write = rx_valid && (rx_data.req.opcode == OP_WRITE);
  assign is_ack   = rx_valid && (rx_data.ack.opcode == OP_ACK);
  assign in_order = (rx_data.req.psn == exp_psn[rx_qp]);

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      wr_req_valid  <= 1'b0;
      ack_req_valid <= 1'b0;
      ack_valid     <= 1'b0;
      psn_drop      <= 1'b0;
      for (int i = 0; i < N_QP; i++) begin
        exp_psn[i] <= '0;
      end
    end else begin
      wr_req_valid  <= is_write && in_order;
      ack_req_valid <= is_write;
      psn_drop      <= is_write && !in_order;
      ack_valid     <= is_ack;
      // Out-of-order words leave the expected PSN alone
      if (is_write && in_order) begin
        exp_psn[rx_qp] <= exp_psn[rx_qp] + 1'b1;
      end
    end
  end

  // Request view into write and ACK payload
  always_ff @(posedge nclk) begin
    wr_req_data.vaddr <= rx_data.req.vaddr;
    wr_req_data.len   <= rx_data.req.len;
    wr_req_data.pid   <= rx_data.req.pid;

    ack_req.qpn    <= rx_data.req.qpn;
    // Same as the word's PSN when in order, the expected one for a NAK
    ack_req.psn    <= exp_psn[rx_qp];
    ack_req.pid    <= rx_data.req.pid;
    ack_req.is_nak <= !in_order;
  end

  // ACK view into the user completion
  always_ff @(posedge nclk) begin
    ack_data.qpn    <= rx_data.ack.qpn;
    ack_data.pid    <= rx_data.ack.pid;
    ack_data.is_nak <= rx_data.ack.is_nak;
  end

  // Remote peer only uses configured queue pairs
  qpn_range_a: assert property (
    @(posedge nclk) disable iff (!nresetn)
    rx_valid |-> (rx_data.req.qpn < N_QP)
  ) else $error("received word for qpn %0d outside N_QP", rx_data.req.qpn);

endmodule

/* source/pkt_counters.sv */
/*
 * Received, transmitted and PSN-drop packet counters
 */
`timescale 1ns/1ps

module pkt_counters (
  input  logic        nclk,
  input  logic        nresetn,
  input  logic        tx_valid,
  input  logic        rx_valid,
  input  logic        psn_drop,
  output logic [31:0] rx_pkt_count,
  output logic [31:0] tx_pkt_count,
  output logic [31:0] psn_drop_count
);

  localparam int N_CNT = 3;

  logic [N_CNT-1:0] strobe;
  logic [31:0]      count [N_CNT];

  // Slot order rx, tx, drop
  assign strobe = {psn_drop, tx_valid, rx_valid};

  // Plain wrap at 2^32
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      for (int i = 0; i < N_CNT; i++) begin
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (strobe[i]) begin
          count[i] <= count[i] + 32'd1;
        end
      end
    end
  end

  assign rx_pkt_count   = count[0];
  assign tx_pkt_count   = count[1];
  assign psn_drop_count = count[2];

endmodule

/* source/roce_lite_stack.sv */
/*
 * RDMA reliable-connection engine top, flow control,
 * transmit and receive engines and packet counters
 */
`timescale 1ns/1ps

module roce_lite_stack
  import rdma_pkg::*;
#(
  parameter int N_QP            = 4,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic        nclk,
  input  logic        nresetn,

  // User send queue
  input  logic        sq_valid,
  output logic        sq_ready,
  input  rdma_sq_t    sq_data,

  // Network
  output logic        tx_valid,
  output net_word_u   tx_data,
  input  logic        rx_valid,
  input  net_word_u   rx_data,

  // Memory requests
  output logic        rd_req_valid,
  output mem_cmd_t    rd_req_data,
  output logic        wr_req_valid,
  output mem_cmd_t    wr_req_data,

  // User completions
  output logic        ack_valid,
  output rdma_ack_t   ack_data,

  // Statistics
  output logic [31:0] rx_pkt_count,
  output logic [31:0] tx_pkt_count,
  output logic [31:0] psn_drop_count
);

  logic     sq_accept;
  logic     tx_sq_ready;
  logic     ack_req_valid;
  ack_req_t ack_req;
  logic     psn_drop;

  sq_flow_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) sq_flow_ctrl_i (
    .nclk        (nclk),
    .nresetn     (nresetn),
    .sq_valid    (sq_valid),
    .tx_sq_ready (tx_sq_ready),
    .ack_valid   (ack_valid),
    .sq_ready    (sq_ready),
    .sq_accept   (sq_accept)
  );

  tx_engine #(
    .N_QP (N_QP)
  ) tx_engine_i (
    .nclk          (nclk),
    .nresetn       (nresetn),
    .sq_accept     (sq_accept),
    .sq_data       (sq_data),
    .ack_req_valid (ack_req_valid),
    .ack_req       (ack_req),
    .tx_sq_ready   (tx_sq_ready),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data),
    .rd_req_valid  (rd_req_valid),
    .rd_req_data   (rd_req_data)
  );

  rx_engine #(
    .N_QP (N_QP)
  ) rx_engine_i (
    .nclk          (nclk),
    .nresetn       (nresetn),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .wr_req_valid  (wr_req_valid),
    .wr_req_data   (wr_req_data),
    .ack_req_valid (ack_req_valid),
    .ack_req       (ack_req),
    .ack_valid     (ack_valid),
    .ack_data      (ack_data),
    .psn_drop      (psn_drop)
  );

  pkt_counters pkt_counters_i (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .tx_valid       (tx_valid),
    .rx_valid       (rx_valid),
    .psn_drop       (psn_drop),
    .rx_pkt_count   (rx_pkt_count),
    .tx_pkt_count   (tx_pkt_count),
    .psn_drop_count (psn_drop_count)
  );

endmodule

/* verif/roce_lite_tb.sv */
/*
 * Testbench for the RDMA reliable-connection engine, with clock, reset,
 * DUT instance, strobe capture, check task and directed tests
 */
`timescale 1ns/1ps

module roce_lite_tb
  import rdma_pkg::*;
();

  localparam int N_QP            = 4;
  localparam int MAX_OUTSTANDING = 4;
  localparam int TIMEOUT         = 50;
  localparam int Q_TX            = 0;
  localparam int Q_RD            = 1;
  localparam int Q_WR            = 2;
  localparam int Q_ACK           = 3;

  logic        nclk;
  logic        nresetn;
  logic        sq_valid;
  logic        sq_ready;
  rdma_sq_t    sq_data;
  logic        tx_valid;
  net_word_u   tx_data;
  logic        rx_valid;
  net_word_u   rx_data;
  logic        rd_req_valid;
  mem_cmd_t    rd_req_data;
  logic        wr_req_valid;
  mem_cmd_t    wr_req_data;
  logic        ack_valid;
  rdma_ack_t   ack_data;
  logic [31:0] rx_pkt_count;
  logic [31:0] tx_pkt_count;
  logic [31:0] psn_drop_count;

  // Output strobes captured at the falling edge
  logic [63:0] tx_q [$];
  logic [31:0] rd_q [$];
  logic [31:0] wr_q [$];
  logic [8:0]  ack_q [$];

  // Expected PSNs per qpn on each side
  logic [PSN_BITS-1:0] send_psn [16];
  logic [PSN_BITS-1:0] exp_psn  [16];

  int errors;
  int checks;
  int rx_sent;
  int tx_expected;
  int drops_expected;

  roce_lite_stack #(
    .N_QP            (N_QP),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) roce_lite_stack_i (.*);

  initial begin
    nclk = 1'b0;
    forever #5 nclk = ~nclk;
  end

  always @(negedge nclk) begin
    if (nresetn) begin
      if (tx_valid)
        tx_q.push_back(tx_data);
      if (rd_req_valid)
        rd_q.push_back(rd_req_data);
      if (wr_req_valid)
        wr_q.push_back(wr_req_data);
      if (ack_valid)
        ack_q.push_back(ack_data);
    end
  end

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic int pending(input int which);
    case (which)
      Q_TX:    return tx_q.size();
      Q_RD:    return rd_q.size();
      Q_WR:    return wr_q.size();
      default: return ack_q.size();
    endcase
  endfunction

  task automatic wait_strobe(input int which, input string what, output bit seen);
    for (int i = 0; i < TIMEOUT && pending(which) == 0; i++)
      @(negedge nclk);
    seen = (pending(which) != 0);
    if (!seen) begin
      errors++;
      $display("Timeout: %s never arrived", what);
    end
  endtask

  task automatic drive_rx(input logic [63:0] word);
    rx_valid = 1'b1;
    rx_data  = word;
    @(negedge nclk);
    rx_valid = 1'b0;
    rx_sent++;
  endtask

  // Post one WRITE and check its request header and read request
  task automatic send_write(input string name, input logic [3:0] qpn, input logic [3:0] pid);
    logic [15:0] vaddr;
    logic [11:0] len;
    logic [63:0] exp_word;
    bit          accepted;
    bit          seen;
    vaddr    = 16'($urandom());
    len      = 12'($urandom());
    sq_data  = {OP_WRITE, qpn, pid, vaddr, len};
    sq_valid = 1'b1;
    for (int i = 0; i < TIMEOUT && !sq_ready; i++)
      @(negedge nclk);
    accepted = sq_ready;
    if (accepted)
      @(negedge nclk);
    sq_valid = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Timeout: %s command on qpn %0d was never accepted", name, qpn);
    end else begin
      exp_word      = {OP_WRITE, qpn, send_psn[qpn], pid, vaddr, len};
      send_psn[qpn] = send_psn[qpn] + 24'd1;
      tx_expected++;
      wait_strobe(Q_TX, {name, " tx request word"}, seen);
      if (seen)
        check({name, " tx word"}, exp_word, tx_q.pop_front());
      wait_strobe(Q_RD, {name, " rd_req"}, seen);
      if (seen)
        check({name, " rd_req"}, 64'({vaddr, len, pid}), 64'(rd_q.pop_front()));
    end
  endtask

  // ACK or NAK word from the remote side, echoed to the user
  task automatic return_ack(input string name, input logic [3:0] qpn, input logic [3:0] pid,
                            input logic is_nak);
    bit seen;
    drive_rx({OP_ACK, qpn, 24'd0, pid, is_nak, 27'd0});
    wait_strobe(Q_ACK, {name, " ack_valid"}, seen);
    if (seen)
      check({name, " ack_data"}, 64'({qpn, pid, is_nak}), 64'(ack_q.pop_front()));
  endtask

  task automatic receive_write(input string name, input logic [3:0] qpn,
                               input logic [PSN_BITS-1:0] psn, input logic [3:0] pid);
    logic [15:0] vaddr;
    logic [11:0] len;
    logic [63:0] exp_word;
    bit          in_order;
    bit          seen;
    vaddr    = 16'($urandom());
    len      = 12'($urandom());
    in_order = (psn == exp_psn[qpn]);
    drive_rx({OP_WRITE, qpn, psn, pid, vaddr, len});
    tx_expected++;
    if (in_order) begin
      exp_word     = {OP_ACK, qpn, psn, pid, 1'b0, 27'd0};
      exp_psn[qpn] = exp_psn[qpn] + 24'd1;
      wait_strobe(Q_WR, {name, " wr_req"}, seen);
      if (seen)
        check({name, " wr_req"}, 64'({vaddr, len, pid}), 64'(wr_q.pop_front()));
    end else begin
      // NAK reports the PSN still expected
      exp_word = {OP_ACK, qpn, exp_psn[qpn], pid, 1'b1, 27'd0};
      drops_expected++;
    end
    wait_strobe(Q_TX, {name, " tx ACK word"}, seen);
    if (seen)
      check({name, " tx ACK word"}, exp_word, tx_q.pop_front());
    if (!in_order)
      check({name, " no wr_req"}, 64'd0, 64'(wr_q.size()));
  endtask

  task automatic send_path();
    send_write("send qp1 first", 4'd1, 4'd3);
    send_write("send qp1 second", 4'd1, 4'd5);
    send_write("send qp2", 4'd2, 4'd9);
    // Free the slots for the flow control test
    return_ack("send drain", 4'd1, 4'd3, 1'b0);
    return_ack("send drain", 4'd1, 4'd5, 1'b0);
    return_ack("send drain", 4'd2, 4'd9, 1'b0);
  endtask

  task automatic flow_control();
    for (int i = 0; i < MAX_OUTSTANDING; i++)
      send_write("flow fill", 4'd3, 4'(i));
    check("flow sq_ready at limit", 64'd0, 64'(sq_ready));
    return_ack("flow ack", 4'd3, 4'd0, 1'b0);
    send_write("flow fifth", 4'd3, 4'd4);
  endtask

  task automatic in_order_receive();
    receive_write("in order psn0", 4'd0, 24'd0, 4'd6);
    receive_write("in order psn1", 4'd0, 24'd1, 4'd7);
  endtask

  task automatic out_of_order_receive();
    receive_write("out of order", 4'd0, 24'd5, 4'd8);
    @(negedge nclk);
    check("out of order drop count", 64'(drops_expected), 64'(psn_drop_count));
  endtask

  task automatic nak_to_user();
    return_ack("nak to user", 4'd3, 4'd2, 1'b1);
  endtask

  task automatic counter_totals();
    repeat (3) @(negedge nclk);
    check("counters rx", 64'(rx_sent), 64'(rx_pkt_count));
    check("counters tx", 64'(tx_expected), 64'(tx_pkt_count));
    check("counters drop", 64'd1, 64'(psn_drop_count));
    check("counters unclaimed tx words", 64'd0, 64'(tx_q.size()));
  endtask

  initial begin
    void'($urandom(53));
    errors         = 0;
    checks         = 0;
    rx_sent        = 0;
    tx_expected    = 0;
    drops_expected = 0;
    send_psn       = '{default: '0};
    exp_psn        = '{default: '0};
    nresetn        = 1'b0;
    sq_valid       = 1'b0;
    sq_data        = '0;
    rx_valid       = 1'b0;
    rx_data        = '0;
    repeat (2) @(posedge nclk);
    @(negedge nclk);
    nresetn = 1'b1;
    @(negedge nclk);
    check("reset sq_ready", 64'd1, 64'(sq_ready));

    send_path();
    flow_control();
    in_order_receive();
    out_of_order_receive();
    nak_to_user();
    counter_totals();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* roce_lite_stack.f */
source/rdma_pkg.sv
source/sq_flow_ctrl.sv
source/tx_engine.sv
source/rx_engine.sv
source/pkt_counters.sv
source/roce_lite_stack.sv
verif/roce_lite_tb.sv

/* Makefile */
# Verilator build and run for the RDMA engine testbench

TOP      ?= roce_lite_tb
FILELIST ?= roce_lite_stack.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: compile
	out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
